//--- source/axi_mem_pkg.sv
package axi_mem_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int STRB_W     = DATA_W / 8;
  localparam int MEM_WORDS  = 256; // byte range 0 to 1023.
  localparam int WORD_IDX_W = 8;
  localparam int LAT_W      = 3; // extra delay of 0 to 7 cycles.

  localparam logic [7:0] LFSR_SEED = 8'hAA;

  typedef enum logic [1:0] {
    OKAY   = 2'd0,
    SLVERR = 2'd2
  } resp_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT,
    RD_RESP
  } rd_state_e;

  typedef enum logic [2:0] {
    WR_IDLE,
    WR_GOT_ADDR,
    WR_GOT_DATA,
    WR_WAIT,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    GNT_FETCH,
    GNT_DATA
  } grant_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } ar_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } w_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    resp_e             resp;
  } r_t;

  typedef struct packed {
    resp_e resp;
  } b_t;

endpackage

//--- source/axi_mem_top.sv
`timescale 1ns/1ps

module axi_mem_top (
  input  logic             clk,
  input  logic             rstn,
  input  axi_mem_pkg::ar_t f_ar,
  input  logic             f_arvalid,
  output logic             f_arready,
  output axi_mem_pkg::r_t  f_r,
  output logic             f_rvalid,
  input  logic             f_rready,
  input  axi_mem_pkg::ar_t d_ar,
  input  logic             d_arvalid,
  output logic             d_arready,
  output axi_mem_pkg::r_t  d_r,
  output logic             d_rvalid,
  input  logic             d_rready,
  input  axi_mem_pkg::aw_t d_aw,
  input  logic             d_awvalid,
  output logic             d_awready,
  input  axi_mem_pkg::w_t  d_w,
  input  logic             d_wvalid,
  output logic             d_wready,
  output axi_mem_pkg::b_t  d_b,
  output logic             d_bvalid,
  input  logic             d_bready
);

  axi_mem_pkg::ar_t s_ar;
  axi_mem_pkg::r_t  s_r;
  axi_mem_pkg::aw_t s_aw;
  axi_mem_pkg::w_t  s_w;
  axi_mem_pkg::b_t  s_b;
  logic s_arvalid, s_arready, s_rvalid, s_rready;
  logic s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;

  logic [7:0]                         rand_val;
  logic [axi_mem_pkg::WORD_IDX_W-1:0] mem_rd_idx;
  logic [axi_mem_pkg::DATA_W-1:0]     mem_rd_data;
  logic                               mem_wr_en;
  logic [axi_mem_pkg::WORD_IDX_W-1:0] mem_wr_idx;
  logic [axi_mem_pkg::DATA_W-1:0]     mem_wr_data;
  logic [axi_mem_pkg::STRB_W-1:0]     mem_wr_strb;

  axi_read_arbiter u_arb (.*);

  axi_sram_slave u_slave (
    .clk, .rstn,
    .ar(s_ar), .arvalid(s_arvalid), .arready(s_arready),
    .r(s_r), .rvalid(s_rvalid), .rready(s_rready),
    .aw(s_aw), .awvalid(s_awvalid), .awready(s_awready),
    .w(s_w), .wvalid(s_wvalid), .wready(s_wready),
    .b(s_b), .bvalid(s_bvalid), .bready(s_bready),
    .rand_val, .mem_rd_idx, .mem_rd_data,
    .mem_wr_en, .mem_wr_idx, .mem_wr_data, .mem_wr_strb
  );

  lfsr8 u_lfsr (.clk, .rstn, .out(rand_val));

  sram_array u_mem (
    .clk, .rd_idx(mem_rd_idx), .rd_data(mem_rd_data),
    .wr_en(mem_wr_en), .wr_idx(mem_wr_idx), .wr_data(mem_wr_data), .wr_strb(mem_wr_strb)
  );

endmodule

//--- source/axi_read_arbiter.sv
`timescale 1ns/1ps

module axi_read_arbiter (
  input  logic              clk,
  input  logic              rstn,
  // fetch master
  input  axi_mem_pkg::ar_t  f_ar,
  input  logic              f_arvalid,
  output logic              f_arready,
  output axi_mem_pkg::r_t   f_r,
  output logic              f_rvalid,
  input  logic              f_rready,
  // data master
  input  axi_mem_pkg::ar_t  d_ar,
  input  logic              d_arvalid,
  output logic              d_arready,
  output axi_mem_pkg::r_t   d_r,
  output logic              d_rvalid,
  input  logic              d_rready,
  input  axi_mem_pkg::aw_t  d_aw,
  input  logic              d_awvalid,
  output logic              d_awready,
  input  axi_mem_pkg::w_t   d_w,
  input  logic              d_wvalid,
  output logic              d_wready,
  output axi_mem_pkg::b_t   d_b,
  output logic              d_bvalid,
  input  logic              d_bready,
  // slave side
  output axi_mem_pkg::ar_t  s_ar,
  output logic              s_arvalid,
  input  logic              s_arready,
  input  axi_mem_pkg::r_t   s_r,
  input  logic              s_rvalid,
  output logic              s_rready,
  output axi_mem_pkg::aw_t  s_aw,
  output logic              s_awvalid,
  input  logic              s_awready,
  output axi_mem_pkg::w_t   s_w,
  output logic              s_wvalid,
  input  logic              s_wready,
  input  axi_mem_pkg::b_t   s_b,
  input  logic              s_bvalid,
  output logic              s_bready
);

  logic                busy;
  axi_mem_pkg::grant_e owner;
  axi_mem_pkg::grant_e prio;
  axi_mem_pkg::grant_e pick;
  axi_mem_pkg::grant_e sel;

  // round robin among the requesters, prio breaks a tie.
  always_comb begin
    if (f_arvalid && d_arvalid) begin
      pick = prio;
    end else if (f_arvalid) begin
      pick = axi_mem_pkg::GNT_FETCH;
    end else begin
      pick = axi_mem_pkg::GNT_DATA;
    end
  end

  assign sel = busy ? owner : pick;

  assign s_ar      = (sel == axi_mem_pkg::GNT_FETCH) ? f_ar : d_ar;
  assign s_arvalid = !busy && (f_arvalid || d_arvalid);
  assign f_arready = !busy && (sel == axi_mem_pkg::GNT_FETCH) && s_arready;
  assign d_arready = !busy && (sel == axi_mem_pkg::GNT_DATA) && s_arready;

  assign f_r      = s_r;
  assign d_r      = s_r;
  assign f_rvalid = busy && (owner == axi_mem_pkg::GNT_FETCH) && s_rvalid;
  assign d_rvalid = busy && (owner == axi_mem_pkg::GNT_DATA) && s_rvalid;
  assign s_rready = busy && ((owner == axi_mem_pkg::GNT_FETCH) ? f_rready : d_rready);

  always_ff @(posedge clk) begin
    if (rstn) begin
      busy  <= 1'b0;
      owner <= axi_mem_pkg::GNT_DATA;
      prio  <= axi_mem_pkg::GNT_DATA;
    end else if (s_arvalid && s_arready) begin
      busy  <= 1'b1; // locked until the R transfer.
      owner <= sel;
    end else if (s_rvalid && s_rready) begin
      busy <= 1'b0;
      prio <= (owner == axi_mem_pkg::GNT_FETCH) ? axi_mem_pkg::GNT_DATA
                                               : axi_mem_pkg::GNT_FETCH;
    end
  end

  // writes come only from the data port.
  assign s_aw      = d_aw;
  assign s_awvalid = d_awvalid;
  assign d_awready = s_awready;
  assign s_w       = d_w;
  assign s_wvalid  = d_wvalid;
  assign d_wready  = s_wready;
  assign d_b       = s_b;
  assign d_bvalid  = s_bvalid;
  assign s_bready  = d_bready;

endmodule

//--- source/axi_sram_slave.sv
`timescale 1ns/1ps

module axi_sram_slave (
  input  logic                               clk,
  input  logic                               rstn,
  input  axi_mem_pkg::ar_t                   ar,
  input  logic                               arvalid,
  output logic                               arready,
  output axi_mem_pkg::r_t                    r,
  output logic                               rvalid,
  input  logic                               rready,
  input  axi_mem_pkg::aw_t                   aw,
  input  logic                               awvalid,
  output logic                               awready,
  input  axi_mem_pkg::w_t                    w,
  input  logic                               wvalid,
  output logic                               wready,
  output axi_mem_pkg::b_t                    b,
  output logic                               bvalid,
  input  logic                               bready,
  input  logic [7:0]                         rand_val,
  output logic [axi_mem_pkg::WORD_IDX_W-1:0] mem_rd_idx,
  input  logic [axi_mem_pkg::DATA_W-1:0]     mem_rd_data,
  output logic                               mem_wr_en,
  output logic [axi_mem_pkg::WORD_IDX_W-1:0] mem_wr_idx,
  output logic [axi_mem_pkg::DATA_W-1:0]     mem_wr_data,
  output logic [axi_mem_pkg::STRB_W-1:0]     mem_wr_strb
);

  axi_mem_pkg::rd_state_e        rd_state;
  axi_mem_pkg::wr_state_e        wr_state;
  logic [axi_mem_pkg::LAT_W-1:0] rd_cnt;
  logic [axi_mem_pkg::LAT_W-1:0] wr_cnt;
  logic [axi_mem_pkg::ADDR_W-1:0] raddr;
  logic [axi_mem_pkg::ADDR_W-1:0] waddr;
  axi_mem_pkg::w_t               wbuf;
  logic                          aw_hs;
  logic                          w_hs;
  logic                          rd_fire;
  logic                          wr_fire;

  function automatic logic in_range(input logic [axi_mem_pkg::ADDR_W-1:0] addr);
    return addr < axi_mem_pkg::MEM_WORDS * 4;
  endfunction

  assign arready = (rd_state == axi_mem_pkg::RD_IDLE);
  assign rvalid  = (rd_state == axi_mem_pkg::RD_RESP);
  assign awready = (wr_state == axi_mem_pkg::WR_IDLE) || (wr_state == axi_mem_pkg::WR_GOT_DATA);
  assign wready  = (wr_state == axi_mem_pkg::WR_IDLE) || (wr_state == axi_mem_pkg::WR_GOT_ADDR);
  assign bvalid  = (wr_state == axi_mem_pkg::WR_RESP);

  assign aw_hs   = awvalid && awready;
  assign w_hs    = wvalid && wready;
  assign rd_fire = (rd_state == axi_mem_pkg::RD_WAIT) && (rd_cnt == '0);
  assign wr_fire = (wr_state == axi_mem_pkg::WR_WAIT) && (wr_cnt == '0);

  assign mem_rd_idx  = raddr[axi_mem_pkg::WORD_IDX_W+1:2]; // word aligned.
  assign mem_wr_idx  = waddr[axi_mem_pkg::WORD_IDX_W+1:2];
  assign mem_wr_data = wbuf.data;
  assign mem_wr_strb = wbuf.strb;
  assign mem_wr_en   = wr_fire && in_range(waddr); // out of range writes are dropped.

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_state <= axi_mem_pkg::RD_IDLE;
      rd_cnt   <= '0;
    end else begin
      case (rd_state)
        axi_mem_pkg::RD_IDLE: begin
          if (arvalid) begin
            rd_cnt   <= rand_val[axi_mem_pkg::LAT_W-1:0];
            rd_state <= axi_mem_pkg::RD_WAIT;
          end
        end
        axi_mem_pkg::RD_WAIT: begin
          if (rd_fire) begin
            rd_state <= axi_mem_pkg::RD_RESP;
          end else begin
            rd_cnt <= rd_cnt - 1'b1;
          end
        end
        axi_mem_pkg::RD_RESP: begin
          if (rready) begin
            rd_state <= axi_mem_pkg::RD_IDLE;
          end
        end
        default: rd_state <= axi_mem_pkg::RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (arvalid && arready) begin
      raddr <= ar.addr;
    end
    if (rd_fire) begin
      r.data <= in_range(raddr) ? mem_rd_data : '0;
      r.resp <= in_range(raddr) ? axi_mem_pkg::OKAY : axi_mem_pkg::SLVERR;
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_state <= axi_mem_pkg::WR_IDLE;
      wr_cnt   <= '0;
    end else begin
      case (wr_state)
        axi_mem_pkg::WR_IDLE: begin
          if (aw_hs && w_hs) begin
            wr_cnt   <= rand_val[axi_mem_pkg::LAT_W-1:0];
            wr_state <= axi_mem_pkg::WR_WAIT;
          end else if (aw_hs) begin
            wr_state <= axi_mem_pkg::WR_GOT_ADDR;
          end else if (w_hs) begin
            wr_state <= axi_mem_pkg::WR_GOT_DATA;
          end
        end
        axi_mem_pkg::WR_GOT_ADDR, axi_mem_pkg::WR_GOT_DATA: begin
          if (aw_hs || w_hs) begin // the missing half arrived.
            wr_cnt   <= rand_val[axi_mem_pkg::LAT_W-1:0];
            wr_state <= axi_mem_pkg::WR_WAIT;
          end
        end
        axi_mem_pkg::WR_WAIT: begin
          if (wr_fire) begin
            wr_state <= axi_mem_pkg::WR_RESP;
          end else begin
            wr_cnt <= wr_cnt - 1'b1;
          end
        end
        axi_mem_pkg::WR_RESP: begin
          if (bready) begin
            wr_state <= axi_mem_pkg::WR_IDLE;
          end
        end
        default: wr_state <= axi_mem_pkg::WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      waddr <= aw.addr;
    end
    if (w_hs) begin
      wbuf <= w;
    end
    if (wr_fire) begin
      b.resp <= in_range(waddr) ? axi_mem_pkg::OKAY : axi_mem_pkg::SLVERR;
    end
  end

endmodule

//--- source/lfsr8.sv
`timescale 1ns/1ps

module lfsr8 (
  input  logic       clk,
  input  logic       rstn,
  output logic [7:0] out
);

  // taps for x^8 + x^6 + x^5 + x^4 + 1, shifted right.
  localparam logic [7:0] TAPS = 8'hB8;

  logic [7:0] next_val;

  always_comb begin
    next_val = {1'b0, out[7:1]};
    if (out[0]) begin
      next_val = next_val ^ TAPS; // feedback into tapped bits.
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      out <= axi_mem_pkg::LFSR_SEED;
    end else begin
      out <= next_val; // nonzero seed keeps it off the all-zero state.
    end
  end

endmodule

//--- source/sram_array.sv
`timescale 1ns/1ps

module sram_array (
  input  logic                                clk,
  input  logic [axi_mem_pkg::WORD_IDX_W-1:0]  rd_idx,
  output logic [axi_mem_pkg::DATA_W-1:0]      rd_data,
  input  logic                                wr_en,
  input  logic [axi_mem_pkg::WORD_IDX_W-1:0]  wr_idx,
  input  logic [axi_mem_pkg::DATA_W-1:0]      wr_data,
  input  logic [axi_mem_pkg::STRB_W-1:0]      wr_strb
);

  logic [axi_mem_pkg::DATA_W-1:0] mem [axi_mem_pkg::MEM_WORDS];

  // byte lanes with their strobe bit set are written.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < axi_mem_pkg::STRB_W; i++) begin
        if (wr_strb[i]) begin
          mem[wr_idx][i*8 +: 8] <= wr_data[i*8 +: 8];
        end
      end
    end
  end

  assign rd_data = mem[rd_idx]; // asynchronous read.

endmodule

//--- tb.f
source/axi_mem_pkg.sv
source/lfsr8.sv
source/sram_array.sv
source/axi_sram_slave.sv
source/axi_read_arbiter.sv
source/axi_mem_top.sv
testbench/axi_mem_asserts.sv
testbench/tb_axi_mem.sv

//--- testbench/axi_mem_asserts.sv
`timescale 1ns/1ps

module axi_mem_asserts (
  input logic            clk,
  input logic            rstn,
  input logic            arready,
  input axi_mem_pkg::r_t r,
  input logic            rvalid,
  input logic            rready,
  input logic            awready,
  input logic            wready,
  input axi_mem_pkg::b_t b,
  input logic            bvalid,
  input logic            bready
);

  int fail_cnt = 0;

  r_hold: assert property (@(posedge clk) disable iff (rstn)
    rvalid && !rready |=> rvalid && $stable(r))
    else begin
      $error("rvalid dropped or r changed before rready");
      fail_cnt++;
    end

  b_hold: assert property (@(posedge clk) disable iff (rstn)
    bvalid && !bready |=> bvalid && $stable(b))
    else begin
      $error("bvalid dropped or b changed before bready");
      fail_cnt++;
    end

  // one read in flight at a time.
  ar_blocked: assert property (@(posedge clk) disable iff (rstn)
    !arready && !(rvalid && rready) |=> !arready)
    else begin
      $error("arready rose before the read response was taken");
      fail_cnt++;
    end

  reset_state: assert property (@(posedge clk)
    $fell(rstn) |-> arready && awready && wready && !rvalid && !bvalid)
    else begin
      $error("channel flags wrong in the first cycle after reset");
      fail_cnt++;
    end

endmodule

bind axi_sram_slave axi_mem_asserts u_asserts (.*);

//--- testbench/tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem;

  localparam int SEED       = 32'hd477_7416;
  localparam int N_INIT     = axi_mem_pkg::MEM_WORDS; // one full write per word first.
  localparam int N_DATA     = 100;
  localparam int N_FETCH    = 120;
  localparam int N_TXN      = 600;
  localparam int TIMEOUT_NS = N_TXN * 40 * 20;
  localparam int LIMIT      = axi_mem_pkg::MEM_WORDS * 4;

  logic clk, rstn;
  axi_mem_pkg::ar_t f_ar, d_ar;
  axi_mem_pkg::r_t  f_r, d_r;
  axi_mem_pkg::aw_t d_aw;
  axi_mem_pkg::w_t  d_w;
  axi_mem_pkg::b_t  d_b;
  logic f_arvalid, f_arready, f_rvalid, f_rready;
  logic d_arvalid, d_arready, d_rvalid, d_rready;
  logic d_awvalid, d_awready, d_wvalid, d_wready, d_bvalid, d_bready;

  logic [axi_mem_pkg::DATA_W-1:0] model [axi_mem_pkg::MEM_WORDS];
  integer d_seed, f_seed;
  int     cyc;
  logic   init_done;
  logic   f_busy, d_rbusy, d_wbusy; // a response is owed on that channel.

  axi_mem_top uut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired, traffic stalled before all transactions completed");
    $display("TEST FAIL");
    $fatal(1);
  end

  task automatic fail_now(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_r(input string who, input axi_mem_pkg::r_t got,
                         input axi_mem_pkg::r_t exp);
    if (got !== exp) begin
      fail_now($sformatf("%s read gave %h %s, expected %h %s", who, got.data,
                         got.resp.name(), exp.data, exp.resp.name()));
    end
  endtask

  task automatic check_b(input axi_mem_pkg::b_t got, input axi_mem_pkg::b_t exp);
    if (got !== exp) begin
      fail_now($sformatf("write resp %s, expected %s", got.resp.name(), exp.resp.name()));
    end
  endtask

  task automatic compare_flag(input string what, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic verify_latency(input string what, input int lat);
    if (lat < 1 || lat > (1 << axi_mem_pkg::LAT_W)) begin
      fail_now($sformatf("%s response after %0d cycles, expected 1 to 8", what, lat));
    end
  endtask

  function automatic axi_mem_pkg::r_t expect_r(input logic [31:0] addr);
    axi_mem_pkg::r_t e;
    e.data = (addr < LIMIT) ? model[addr[9:2]] : '0;
    e.resp = (addr < LIMIT) ? axi_mem_pkg::OKAY : axi_mem_pkg::SLVERR;
    return e;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input axi_mem_pkg::w_t w);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (w.strb[i]) res[i*8 +: 8] = w.data[i*8 +: 8];
    end
    return res;
  endfunction

  task automatic fetch_read(input logic [31:0] addr);
    int t_ar;
    int lat;
    int others;
    lat       = 0;
    others    = 0;
    f_ar.addr = addr;
    f_arvalid = 1'b1;
    @(negedge clk);
    while (!f_arready) begin
      if (d_arvalid && d_arready) others++; // data read granted ahead of us.
      @(negedge clk);
    end
    if (others > 1) fail_now("fetch port waited through more than one data read");
    t_ar = cyc + 1;
    @(posedge clk);
    #1;
    f_arvalid = 1'b0;
    f_busy    = 1'b1;
    forever begin
      @(negedge clk);
      if (f_rvalid && lat == 0) begin
        lat = cyc - t_ar;
        verify_latency("fetch read", lat);
      end
      if (f_rvalid && f_rready) break;
      @(posedge clk);
      #1;
      f_rready = $random(f_seed);
    end
    check_r("fetch", f_r, expect_r(addr));
    @(posedge clk);
    #1;
    f_busy   = 1'b0;
    f_rready = $random(f_seed);
  endtask

  task automatic data_read(input logic [31:0] addr);
    int t_ar;
    int lat;
    int others;
    lat       = 0;
    others    = 0;
    d_ar.addr = addr;
    d_arvalid = 1'b1;
    @(negedge clk);
    while (!d_arready) begin
      if (f_arvalid && f_arready) others++;
      @(negedge clk);
    end
    if (others > 1) fail_now("data port waited through more than one fetch read");
    t_ar = cyc + 1;
    @(posedge clk);
    #1;
    d_arvalid = 1'b0;
    d_rbusy   = 1'b1;
    forever begin
      @(negedge clk);
      if (d_rvalid && lat == 0) begin
        lat = cyc - t_ar;
        verify_latency("data read", lat);
      end
      if (d_rvalid && d_rready) break;
      @(posedge clk);
      #1;
      d_rready = $random(d_seed);
    end
    check_r("data", d_r, expect_r(addr));
    @(posedge clk);
    #1;
    d_rbusy  = 1'b0;
    d_rready = $random(d_seed);
  endtask

  // order 0 sends AW and W together, 1 sends AW first, 2 sends W first.
  task automatic data_write(input logic [31:0] addr, input axi_mem_pkg::w_t w, input int order);
    int t_aw;
    int t_w;
    int lat;
    logic aw_done;
    logic w_done;
    axi_mem_pkg::b_t exp;
    aw_done   = 1'b0;
    w_done    = 1'b0;
    lat       = 0;
    d_aw.addr = addr;
    d_w       = w;
    d_awvalid = (order != 2);
    d_wvalid  = (order != 1);
    while (!(aw_done && w_done)) begin
      @(negedge clk);
      if (d_awvalid && d_awready) begin
        aw_done = 1'b1;
        t_aw    = cyc + 1;
      end
      if (d_wvalid && d_wready) begin
        w_done = 1'b1;
        t_w    = cyc + 1;
      end
      @(posedge clk);
      #1;
      d_awvalid = !aw_done && (order != 2 || w_done);
      d_wvalid  = !w_done && (order != 1 || aw_done);
    end
    d_wbusy = 1'b1;
    forever begin
      @(negedge clk);
      if (d_bvalid && lat == 0) begin
        lat = cyc - ((t_aw > t_w) ? t_aw : t_w); // counted from the later half.
        verify_latency("write", lat);
      end
      if (d_bvalid && d_bready) break;
      @(posedge clk);
      #1;
      d_bready = $random(d_seed);
    end
    exp.resp = (addr < LIMIT) ? axi_mem_pkg::OKAY : axi_mem_pkg::SLVERR;
    check_b(d_b, exp);
    if (addr < LIMIT) model[addr[9:2]] = merge_bytes(model[addr[9:2]], w);
    @(posedge clk);
    #1;
    d_wbusy  = 1'b0;
    d_bready = $random(d_seed);
  endtask

  // writes stay in words 128 to 255, so fetch reads never race a write.
  task automatic data_traffic();
    logic [31:0]     addr;
    axi_mem_pkg::w_t w;
    logic            oor;
    for (int i = 0; i < N_INIT; i++) begin
      w.data = $random(d_seed);
      w.strb = '1;
      data_write(i * 4, w, i % 3);
    end
    init_done = 1'b1;
    for (int i = 0; i < N_DATA; i++) begin
      oor  = ({$random(d_seed)} % 10 == 0);
      addr = 32'd1024 + ({$random(d_seed)} % 1024) * 4;
      if ($random(d_seed) & 1) begin
        if (!oor) addr = 32'd512 + ({$random(d_seed)} % 128) * 4;
        w.data = $random(d_seed);
        w.strb = $random(d_seed);
        data_write(addr, w, {$random(d_seed)} % 3);
        if (oor || ($random(d_seed) & 1)) data_read(addr & 32'h3ff); // read the word back.
      end else begin
        if (!oor) addr = ({$random(d_seed)} % 256) * 4;
        data_read(addr);
      end
    end
  endtask

  task automatic fetch_traffic();
    wait (init_done);
    @(posedge clk);
    #1;
    for (int i = 0; i < N_FETCH; i++) begin
      if ({$random(f_seed)} % 4 == 0) begin
        @(posedge clk); // idle cycle now and then.
        #1;
      end
      fetch_read(({$random(f_seed)} % 128) * 4);
    end
  endtask

  // a response with nothing owed would be a duplicate.
  always @(negedge clk) begin
    if (!rstn) begin
      if (f_rvalid && !f_busy) fail_now("fetch port saw a read response with no read open");
      if (d_rvalid && !d_rbusy) fail_now("data port saw a read response with no read open");
      if (d_bvalid && !d_wbusy) fail_now("data port saw a write response with no write open");
    end
    if (uut.u_slave.u_asserts.fail_cnt != 0) fail_now("a slave assertion failed");
  end

  initial begin
    d_seed    = SEED;
    f_seed    = SEED + 1;
    cyc       = 0;
    init_done = 1'b0;
    f_busy    = 1'b0;
    d_rbusy   = 1'b0;
    d_wbusy   = 1'b0;
    rstn      = 1'b1;
    f_ar      = '0;
    f_arvalid = 1'b0;
    f_rready  = 1'b0;
    d_ar      = '0;
    d_arvalid = 1'b0;
    d_rready  = 1'b0;
    d_aw      = '0;
    d_awvalid = 1'b0;
    d_w       = '0;
    d_wvalid  = 1'b0;
    d_bready  = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rstn = 1'b0;
    @(negedge clk);
    compare_flag("d_arready after reset", d_arready, 1'b1);
    compare_flag("d_awready after reset", d_awready, 1'b1);
    compare_flag("d_wready after reset", d_wready, 1'b1);
    compare_flag("f_rvalid after reset", f_rvalid, 1'b0);
    compare_flag("d_rvalid after reset", d_rvalid, 1'b0);
    compare_flag("d_bvalid after reset", d_bvalid, 1'b0);
    @(posedge clk);
    #1;
    fork
      data_traffic();
      fetch_traffic();
    join
    if (uut.u_slave.u_asserts.fail_cnt == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("Fail at %0t ns: %0d slave assertions failed", $time,
               uut.u_slave.u_asserts.fail_cnt);
      $display("TEST FAIL");
      $fatal(1);
    end
  end

endmodule
